/* imuldiv.f */
+incdir+.
imuldiv_data_pkg.sv
imuldiv_ctrl_pkg.sv
imuldiv_mul_dpath.sv
imuldiv_mul_ctrl.sv
imuldiv_div_iterative.sv
imuldiv_top.sv
tb_imuldiv.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the imuldiv testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f imuldiv.f --top-module tb_imuldiv -Mdir "$OBJ_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
  echo "test passed"
  exit 0
else
  echo "test failed, see $LOG"
  exit 1
fi

/* tb_imuldiv.sv */
/*
 * imuldiv testbench
 * random and corner mul/div/divu requests checked against a behavioral model
 */
`timescale 1ns/1ps
`include "imuldiv_defs.svh"

module tb_imuldiv;
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int CORNER_OPS   = 3 * 5 * 5;
  localparam int RAND_OPS     = 100;
  localparam int B2B_OPS      = 30;
  localparam int NUM_OPS      = CORNER_OPS + RAND_OPS + B2B_OPS;
  // 40 cycles covers accept, 32 steps, done, stall and idle gap
  localparam int WATCHDOG_NS  = (NUM_OPS * 40 + RESET_CYCLES) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        reset;
  imuldiv_fn_t req_fn;
  operand_t    req_a;
  operand_t    req_b;
  logic        req_val;
  logic        req_rdy;
  result_t     resp_result;
  logic        resp_val;
  logic        resp_rdy;

  integer      seed;
  // one-entry scoreboard, only one op is ever in flight
  result_t     expected;
  // response transfers seen on the port
  int          op_count = 0;

  operand_t    corner_vals [0:4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  imuldiv_fn_t fn_list [0:2] = '{fn_mul, fn_div, fn_divu};

  always #(CLK_PERIOD / 2) clk = ~clk;

  imuldiv_top u_imuldiv_top (
    .clk        (clk),
    .reset      (reset),
    .req_fn     (req_fn),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_result(resp_result),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy)
  );

  // count every response handed over, a lost or repeated answer shows at the end
  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      op_count <= op_count + 1;
    end
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  function automatic result_t model_result(imuldiv_fn_t fn, operand_t a, operand_t b);
    logic signed [2*`IMULDIV_XLEN-1:0] sa;
    logic signed [2*`IMULDIV_XLEN-1:0] sb;
    logic signed [2*`IMULDIV_XLEN-1:0] sq;
    logic signed [2*`IMULDIV_XLEN-1:0] sr;
    operand_t q;
    operand_t r;
    sa = {{`IMULDIV_XLEN{a[`IMULDIV_XLEN-1]}}, a};
    sb = {{`IMULDIV_XLEN{b[`IMULDIV_XLEN-1]}}, b};
    if (fn == fn_mul) begin
      // full signed product
      model_result = sa * sb;
    end else begin
      if (b == '0) begin
        // zero divisor: all-ones quotient, dividend as remainder
        q = '1;
        r = a;
      end else if (fn == fn_divu) begin
        q = a / b;
        r = a % b;
      end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        // signed overflow case
        q = 32'h8000_0000;
        r = '0;
      end else begin
        // 64-bit division truncates toward zero, remainder follows the dividend
        sq = sa / sb;
        sr = sa % sb;
        q  = sq[`IMULDIV_XLEN-1:0];
        r  = sr[`IMULDIV_XLEN-1:0];
      end
      model_result = {r, q};
    end
  endfunction

  // ------------------------------------------------------------
  // stimulus pickers
  // ------------------------------------------------------------

  function automatic operand_t pick_operand();
    logic [31:0] r;
    logic [2:0]  k;
    r = $random(seed);
    k = r[10:8];
    if (k > 3'd4) begin
      k = k - 3'd5;
    end
    // roughly three in eight picks hit a corner value
    if (r[2:0] < 3'd3) begin
      pick_operand = corner_vals[k];
    end else begin
      pick_operand = $random(seed);
    end
  endfunction

  function automatic imuldiv_fn_t pick_fn();
    logic [31:0] r;
    r = $unsigned($random(seed)) % 3;
    case (r)
      32'd0:   pick_fn = fn_mul;
      32'd1:   pick_fn = fn_div;
      default: pick_fn = fn_divu;
    endcase
  endfunction

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  task report_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_result(input string name, input result_t exp_val, input result_t act_val);
    if (act_val !== exp_val) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
      report_fail();
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp_val, act_val);
      report_fail();
    end
  endtask

  // one request through to its response transfer, called at a rising edge
  task automatic run_op(input imuldiv_fn_t fn, input operand_t a, input operand_t b,
                        input int stall, input bit keep_val);
    int i;
    expected = model_result(fn, a, b);
    req_fn   <= fn;
    req_a    <= a;
    req_b    <= b;
    req_val  <= 1'b1;
    resp_rdy <= (stall == 0);
    // accept edge, the previous response must not repeat
    @(posedge clk);
    check_flag("req_rdy", 1'b1, req_rdy);
    check_flag("resp_val", 1'b0, resp_val);
    if (!keep_val) begin
      req_val <= 1'b0;
    end
    // busy through all steps
    for (i = 0; i < `IMULDIV_STEPS; i++) begin
      @(posedge clk);
      check_flag("req_rdy", 1'b0, req_rdy);
      check_flag("resp_val", 1'b0, resp_val);
    end
    @(posedge clk);
    check_flag("resp_val", 1'b1, resp_val);
    check_flag("req_rdy", 1'b0, req_rdy);
    check_result("resp_result", expected, resp_result);
    // back-pressure, response held until resp_rdy rises
    for (i = 0; i < stall; i++) begin
      if (i == stall - 1) begin
        resp_rdy <= 1'b1;
      end
      @(posedge clk);
      check_flag("resp_val", 1'b1, resp_val);
      check_flag("req_rdy", 1'b0, req_rdy);
      check_result("resp_result", expected, resp_result);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    int f;
    int i;
    int j;
    int n;
    int stall;
    int gap;
    imuldiv_fn_t fn;
    operand_t a;
    operand_t b;
    seed     = 32'hf861_65d2;
    reset    <= 1'b1;
    req_fn   <= fn_mul;
    req_a    <= '0;
    req_b    <= '0;
    req_val  <= 1'b0;
    resp_rdy <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_flag("resp_val", 1'b0, resp_val);
    check_flag("req_rdy", 1'b1, req_rdy);
    // every corner pair for every function
    for (f = 0; f < 3; f++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          run_op(fn_list[f], corner_vals[i], corner_vals[j], 0, 1'b0);
        end
      end
    end
    // random mix with stalls and idle gaps
    for (n = 0; n < RAND_OPS; n++) begin
      fn    = pick_fn();
      a     = pick_operand();
      b     = pick_operand();
      stall = $unsigned($random(seed)) % 4;
      gap   = $unsigned($random(seed)) % 2;
      run_op(fn, a, b, stall, 1'b0);
      repeat (gap) begin
        @(posedge clk);
        check_flag("req_rdy", 1'b1, req_rdy);
        check_flag("resp_val", 1'b0, resp_val);
      end
    end
    // back-to-back, req_val never drops
    for (n = 0; n < B2B_OPS; n++) begin
      fn = pick_fn();
      a  = pick_operand();
      b  = pick_operand();
      run_op(fn, a, b, 0, 1'b1);
    end
    req_val <= 1'b0;
    @(posedge clk);
    check_flag("resp_val", 1'b0, resp_val);
    if (op_count == NUM_OPS) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d responses were seen for %0d requests", op_count, NUM_OPS);
      report_fail();
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    report_fail();
  end

endmodule

/* imuldiv_top.sv */
/*
 * imuldiv top
 * routes requests to the multiplier or divider, one in flight
 */
`timescale 1ns/1ps
`include "imuldiv_defs.svh"

module imuldiv_top (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_ctrl_pkg::imuldiv_fn_t req_fn,
  input  imuldiv_data_pkg::operand_t    req_a,
  input  imuldiv_data_pkg::operand_t    req_b,
  input  logic                          req_val,
  output logic                          req_rdy,
  output imuldiv_data_pkg::result_t     resp_result,
  output logic                          resp_val,
  input  logic                          resp_rdy
);
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;

  // in-flight tracking
  logic in_flight;
  logic busy_div;

  logic req_is_div;
  logic req_signed;

  // multiplier wiring
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t mul_result;
  logic    a_en;
  logic    a_mux_sel;
  logic    b_en;
  logic    b_mux_sel;

  // divider wiring
  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  logic    div_resp_rdy;
  result_t div_result;

  // ------------------------------------------------------------
  // request routing
  // ------------------------------------------------------------

  assign req_is_div = (req_fn != fn_mul);
  assign req_signed = (req_fn == fn_div);

  assign req_rdy     = !in_flight && (req_is_div ? div_req_rdy : mul_req_rdy);
  // a unit only sees val when the top would accept
  assign mul_req_val = req_val && !in_flight && !req_is_div;
  assign div_req_val = req_val && !in_flight && req_is_div;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
      busy_div  <= 1'b0;
    end else if (req_val && req_rdy) begin
      in_flight <= 1'b1;
      busy_div  <= req_is_div;
    end else if (resp_val && resp_rdy) begin
      in_flight <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // response select
  // ------------------------------------------------------------

  assign resp_val     = busy_div ? div_resp_val : mul_resp_val;
  assign resp_result  = busy_div ? div_result : mul_result;
  assign mul_resp_rdy = resp_rdy && in_flight && !busy_div;
  assign div_resp_rdy = resp_rdy && in_flight && busy_div;

  imuldiv_mul_dpath u_mul_dpath (
    .clk        (clk),
    .reset      (reset),
    .req_a      (req_a),
    .req_b      (req_b),
    .a_en       (a_en),
    .a_mux_sel  (a_mux_sel),
    .b_en       (b_en),
    .b_mux_sel  (b_mux_sel),
    .b_lsb      (),
    .resp_result(mul_result)
  );

  imuldiv_mul_ctrl u_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .a_en     (a_en),
    .a_mux_sel(a_mux_sel),
    .b_en     (b_en),
    .b_mux_sel(b_mux_sel)
  );

  imuldiv_div_iterative u_div (
    .clk        (clk),
    .reset      (reset),
    .req_val    (div_req_val),
    .req_rdy    (div_req_rdy),
    .req_signed (req_signed),
    .req_a      (req_a),
    .req_b      (req_b),
    .resp_val   (div_resp_val),
    .resp_rdy   (div_resp_rdy),
    .resp_result(div_result)
  );

  // a unit may only answer for an accepted request
  assert property (@(posedge clk) disable iff (reset) resp_val |-> in_flight);

endmodule

/* imuldiv_div_iterative.sv */
/*
 * iterative restoring divider
 * signed and unsigned division, {remainder, quotient} response
 */
`timescale 1ns/1ps
`include "imuldiv_defs.svh"

module imuldiv_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  logic                       req_signed,
  input  imuldiv_data_pkg::operand_t req_a,
  input  imuldiv_data_pkg::operand_t req_b,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output imuldiv_data_pkg::result_t  resp_result
);
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;

  div_state_t state;
  step_t      count;

  // payload
  operand_t rem_reg;
  operand_t quo_reg;
  operand_t dvs_reg;
  logic     sign_a_reg;
  logic     sign_b_reg;
  logic     zero_reg;

  logic     sign_a;
  logic     sign_b;
  logic [`IMULDIV_XLEN:0] shifted;
  logic [`IMULDIV_XLEN:0] diff;
  logic     fits;
  operand_t quo_out;
  operand_t rem_out;

  // sign bits only count for div
  assign sign_a = req_signed && req_a[`IMULDIV_XLEN-1];
  assign sign_b = req_signed && req_b[`IMULDIV_XLEN-1];

  // ------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------

  // next dividend bit into the partial remainder
  assign shifted = {rem_reg, quo_reg[`IMULDIV_XLEN-1]};
  assign diff    = shifted - {1'b0, dvs_reg};
  // no borrow means the divisor goes in
  assign fits    = !diff[`IMULDIV_XLEN];

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_idle;
      count <= '0;
    end else begin
      case (state)
        div_idle: begin
          if (req_val) begin
            state <= div_calc;
            count <= '0;
          end
        end
        div_calc: begin
          if (count == step_t'(`IMULDIV_STEPS - 1)) begin
            state <= div_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        div_done: begin
          if (resp_rdy) begin
            state <= div_idle;
          end
        end
        default: state <= div_idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath registers
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_rdy && req_val) begin
      sign_a_reg <= sign_a;
      sign_b_reg <= sign_b;
      zero_reg   <= (req_b == '0);
      rem_reg    <= '0;
      quo_reg    <= sign_a ? -req_a : req_a;
      dvs_reg    <= sign_b ? -req_b : req_b;
    end else if (state == div_calc) begin
      // quotient bits fill in from the right as dividend bits leave
      rem_reg <= fits ? diff[`IMULDIV_XLEN-1:0] : shifted[`IMULDIV_XLEN-1:0];
      quo_reg <= {quo_reg[`IMULDIV_XLEN-2:0], fits};
    end
  end

  // ------------------------------------------------------------
  // sign fix-up
  // ------------------------------------------------------------

  // zero divisor: every step subtracts zero, so the raw quotient is
  // all ones and the remainder is the dividend magnitude
  assign quo_out = (!zero_reg && (sign_a_reg ^ sign_b_reg)) ? -quo_reg : quo_reg;
  // remainder follows the dividend, this also restores a zero-divisor dividend
  assign rem_out = sign_a_reg ? -rem_reg : rem_reg;

  assign resp_result = {rem_out, quo_out};
  assign req_rdy     = (state == div_idle);
  assign resp_val    = (state == div_done);

  // held result does not move under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp_result));

endmodule

/* imuldiv_mul_ctrl.sv */
/*
 * iterative multiplier control
 * idle/calc/done FSM, step counter and val/rdy handshake
 */
`timescale 1ns/1ps
`include "imuldiv_defs.svh"

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);
  import imuldiv_data_pkg::*;
  import imuldiv_ctrl_pkg::*;

  mul_state_t state;
  step_t      count;
  logic       last_step;

  assign last_step = (count == step_t'(`IMULDIV_STEPS - 1));

  // ------------------------------------------------------------
  // state and step counter
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mul_idle;
      count <= '0;
    end else begin
      case (state)
        mul_idle: begin
          if (req_val) begin
            state <= mul_calc;
            count <= '0;
          end
        end
        mul_calc: begin
          // last step lands in done
          if (last_step) begin
            state <= mul_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        mul_done: begin
          if (resp_rdy) begin
            state <= mul_idle;
          end
        end
        default: state <= mul_idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // outputs, decoded from state
  // ------------------------------------------------------------

  always_comb begin
    req_rdy   = (state == mul_idle);
    resp_val  = (state == mul_done);
    // load on the accept cycle, shift through calc
    a_en      = (state == mul_calc) || (req_rdy && req_val);
    b_en      = a_en;
    a_mux_sel = (state == mul_calc);
    b_mux_sel = (state == mul_calc);
  end

  // never offer a request slot while a result is pending
  assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val));

  // counter only moves forward inside calc, a wrap would show up as zero
  assert property (@(posedge clk) disable iff (reset)
    (state == mul_calc) |=> (state != mul_calc) || (count != '0));

endmodule

/* imuldiv_mul_dpath.sv */
/*
 * iterative multiplier datapath
 * sign-magnitude shift-and-add with final negation
 */
`timescale 1ns/1ps
`include "imuldiv_defs.svh"

module imuldiv_mul_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_data_pkg::operand_t req_a,
  input  imuldiv_data_pkg::operand_t req_b,
  input  logic                       a_en,
  input  logic                       a_mux_sel,
  input  logic                       b_en,
  input  logic                       b_mux_sel,
  output logic                       b_lsb,
  output imuldiv_data_pkg::result_t  resp_result
);
  import imuldiv_data_pkg::*;

  logic     sign_a_reg;
  logic     sign_b_reg;
  result_t  a_reg;
  operand_t b_reg;
  result_t  acc_reg;

  operand_t mag_a;
  operand_t mag_b;

  // ------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------

  // -2^31 maps onto 0x8000_0000, which is the right unsigned magnitude
  assign mag_a = req_a[`IMULDIV_XLEN-1] ? -req_a : req_a;
  assign mag_b = req_b[`IMULDIV_XLEN-1] ? -req_b : req_b;

  // multiplier bit examined this step
  assign b_lsb = b_reg[0];

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
      acc_reg    <= '0;
    end else if (a_en && !a_mux_sel) begin
      // load, keep signs for the final fix-up
      sign_a_reg <= req_a[`IMULDIV_XLEN-1];
      sign_b_reg <= req_b[`IMULDIV_XLEN-1];
      acc_reg    <= '0;
    end else if (a_en && a_mux_sel) begin
      // add the shifted multiplicand when the current bit is set
      acc_reg <= b_lsb ? acc_reg + a_reg : acc_reg;
    end
  end

  // multiplicand, zero-extended then moved left each step
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_sel ? a_reg << 1 : {{`IMULDIV_XLEN{1'b0}}, mag_a};
    end
  end

  // multiplier, moved right so bit 0 is always the next one
  always_ff @(posedge clk) begin
    if (b_en) begin
      b_reg <= b_mux_sel ? b_reg >> 1 : mag_b;
    end
  end

  // negative product when exactly one sign was set
  assign resp_result = (sign_a_reg ^ sign_b_reg) ? -acc_reg : acc_reg;

endmodule

/* imuldiv_ctrl_pkg.sv */
/*
 * imuldiv control types
 * function codes and the state encodings of both iterative units
 */
package imuldiv_ctrl_pkg;

  // request function code
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } imuldiv_fn_t;

  // multiplier FSM
  typedef enum logic [1:0] {
    mul_idle = 2'd0,
    mul_calc = 2'd1,
    mul_done = 2'd2
  } mul_state_t;

  // divider FSM, same shape as the multiplier
  typedef enum logic [1:0] {
    div_idle = 2'd0,
    div_calc = 2'd1,
    div_done = 2'd2
  } div_state_t;

endpackage

/* imuldiv_data_pkg.sv */
/*
 * imuldiv data types
 * vector types for operands, response words and step counters
 */
`include "imuldiv_defs.svh"

package imuldiv_data_pkg;

  // ------------------------------------------------------------
  // payload vectors
  // ------------------------------------------------------------

  // one operand, also used for quotient and remainder
  typedef logic [`IMULDIV_XLEN-1:0] operand_t;

  // full response word
  // mul: signed product, div: {remainder, quotient}
  typedef logic [2*`IMULDIV_XLEN-1:0] result_t;

  // ------------------------------------------------------------
  // control vectors
  // ------------------------------------------------------------

  // counts 0 .. IMULDIV_STEPS-1
  typedef logic [$clog2(`IMULDIV_STEPS)-1:0] step_t;

endpackage

/* imuldiv_defs.svh */
/*
 * imuldiv shared widths
 * operand width and iteration count for the mul/div unit
 */
`ifndef IMULDIV_DEFS_SVH
`define IMULDIV_DEFS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------

// operand width, the result is twice this
`define IMULDIV_XLEN 32

// ------------------------------------------------------------
// iteration
// ------------------------------------------------------------

// one shift step per operand bit
`define IMULDIV_STEPS 32

`endif
